//--- Makefile
TOP = tbLoadQueue

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/ldqModel.svh
`ifndef LDQ_MODEL_SVH
`define LDQ_MODEL_SVH

localparam int MODEL_ENTRIES = 8;
localparam int MODEL_STALL = 6;

typedef struct packed {
  logic [LINE_ADDR_W-1:0] addrE;
  logic [LINE_ADDR_W-1:0] addrO;
  logic [BANK_W-1:0]      banks;
  logic [BLOW_W-1:0]      blow;
  logic                   oh;
  logic                   eh;
  logic                   ol;
  logic                   el;
} accT;

accT                mSlot  [MODEL_ENTRIES];
logic               mValid [MODEL_ENTRIES];
logic [II_W-1:0]    mIi    [MODEL_ENTRIES];
logic               mConfl [MODEL_ENTRIES];
logic               mSmp   [MODEL_ENTRIES];
logic               mSnEnQ;
logic [SNOOP_W-1:0] mSnAddrQ;

// stored load s against store probe p
function automatic logic overlap(input accT s, input accT p);
  logic lo;
  logic hi;
  lo = |(s.banks[HALF_BANKS-1:0] & p.banks[HALF_BANKS-1:0]);
  hi = |(s.banks[BANK_W-1:HALF_BANKS] & p.banks[BANK_W-1:HALF_BANKS]);
  if ((s.blow & p.blow) == '0) return 1'b0;
  return (s.oh && p.oh && s.addrO == p.addrO && hi) ||
         (s.ol && p.ol && s.addrO == p.addrO && lo) ||
         (s.eh && p.eh && s.addrE == p.addrE && hi) ||
         (s.el && p.el && s.addrE == p.addrE && lo);
endfunction

function automatic logic snoopOverlap(input accT s, input logic [SNOOP_W-1:0] sn);
  logic [LINE_ADDR_W-1:0] line;
  logic lo;
  logic hi;
  line = sn[SNOOP_W-1:1];
  lo = s.banks[HALF_BANKS-1:0] != '0;
  hi = s.banks[BANK_W-1:HALF_BANKS] != '0;
  if (s.blow == '0) return 1'b0;
  if (sn[0]) return line == s.addrO && ((s.oh && hi) || (s.ol && lo));
  return line == s.addrE && ((s.eh && hi) || (s.el && lo));
endfunction

function automatic int liveCount();
  int n;
  n = 0;
  for (int i = 0; i < MODEL_ENTRIES; i++) begin
    if (mValid[i]) n++;
  end
  return n;
endfunction

// {hit, confl, snoop-hit} seen on the retire port this cycle
function automatic logic [2:0] expectFree(input logic en, input logic [II_W-1:0] ii);
  logic [2:0] res;
  res = 3'b000;
  for (int i = 0; i < MODEL_ENTRIES; i++) begin
    if (en && mValid[i] && mIi[i] == ii) res = res | {1'b1, mConfl[i], mSmp[i]};
  end
  return res;
endfunction

// one clock edge of the queue
task automatic stepModel(input logic rstIn, input logic exceptIn, input logic newEnIn,
    input accT newAIn, input logic [II_W-1:0] newIiIn, input logic chkEnIn,
    input accT chkAIn, input logic snEnIn, input logic [SNOOP_W-1:0] snAddrIn,
    input logic freeEnIn, input logic [II_W-1:0] freeIiIn);
  logic accept;
  int pick;
  accept = newEnIn && liveCount() < MODEL_STALL;
  pick = -1;
  for (int i = MODEL_ENTRIES - 1; i >= 0; i--) begin
    if (!mValid[i]) pick = i;
  end
  if (rstIn) begin
    for (int i = 0; i < MODEL_ENTRIES; i++) begin
      mValid[i] = 1'b0;
      mConfl[i] = 1'b0;
      mSmp[i] = 1'b0;
    end
  end else if (exceptIn) begin
    for (int i = 0; i < MODEL_ENTRIES; i++) mValid[i] = 1'b0;
  end else begin
    for (int i = 0; i < MODEL_ENTRIES; i++) begin
      if (mValid[i]) begin
        if (chkEnIn && overlap(mSlot[i], chkAIn)) mConfl[i] = 1'b1;
        if (mSnEnQ && snoopOverlap(mSlot[i], mSnAddrQ)) begin
          mConfl[i] = 1'b1;
          mSmp[i] = 1'b1;
        end
        if (freeEnIn && mIi[i] == freeIiIn) mValid[i] = 1'b0;
      end
    end
    if (accept && pick >= 0) begin
      mSlot[pick] = newAIn;
      mIi[pick] = newIiIn;
      mValid[pick] = 1'b1;
      mConfl[pick] = chkEnIn && overlap(newAIn, chkAIn);
      mSmp[pick] = 1'b0;
    end
  end
  mSnEnQ = rstIn ? 1'b0 : snEnIn;
  mSnAddrQ = snAddrIn;
endtask

`endif

//--- bench/tbLoadQueue.sv
`timescale 1ns/1ps

module tbLoadQueue import ldqPkg::*; ();

  `include "ldqModel.svh"

  localparam int CLK_PERIOD = 4;
  localparam int RESET_CYCLES = 4;
  localparam int DIRECTED_CYCLES = 60;
  localparam int RANDOM_CYCLES = 400;
  localparam int MARGIN_CYCLES = 100;

  logic               clk, rst, except;
  logic               newEn, chkEn, snoopEn, freeEn;
  accT                newA, chkA;
  logic [II_W-1:0]    newIi, freeIi;
  logic [SNOOP_W-1:0] snoopAddr;
  logic               freeHit, freeConfl, freeConflSmp, doStall;
  int                 errors, checks, tests, testErrors, nextIi;
  integer             seed;

  loadQueue #(.ENTRIES(MODEL_ENTRIES), .STALL_LIMIT(MODEL_STALL)) dut0 (
    .clk(clk), .rst(rst), .except(except),
    .newEn(newEn), .newAddrE(newA.addrE), .newAddrO(newA.addrO), .newBanks(newA.banks),
    .newBlow(newA.blow), .newIsOH(newA.oh), .newIsEH(newA.eh), .newIsOL(newA.ol),
    .newIsEL(newA.el), .newIi(newIi),
    .chkEn(chkEn), .chkAddrE(chkA.addrE), .chkAddrO(chkA.addrO), .chkBanks(chkA.banks),
    .chkBlow(chkA.blow), .chkIsOH(chkA.oh), .chkIsEH(chkA.eh), .chkIsOL(chkA.ol),
    .chkIsEL(chkA.el),
    .snoopEn(snoopEn), .snoopAddr(snoopAddr), .freeEn(freeEn), .freeIi(freeIi),
    .freeHit(freeHit), .freeConfl(freeConfl), .freeConflSmp(freeConflSmp), .doStall(doStall)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  // model follows the same edges as the DUT
  always @(posedge clk) begin
    stepModel(rst, except, newEn, newA, newIi, chkEn, chkA, snoopEn, snoopAddr,
              freeEn, freeIi);
  end

  always @(negedge clk) begin
    logic [2:0] expected;
    if (!rst) begin
      expected = expectFree(freeEn, freeIi);
      check("freeHit", freeHit, expected[2]);
      check("freeConfl", freeConfl, expected[1]);
      check("freeConflSmp", freeConflSmp, expected[0]);
      check("doStall", doStall, liveCount() >= MODEL_STALL);
    end
  end

  initial begin
    #((RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("timeout: tests did not finish in time");
    $display("Done: errors found");
    $finish;
  end

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic finishTest(input string name);
    tests++;
    $display("test %0d %-20s %0d errors", tests, name, errors - testErrors);
    testErrors = errors;
  endtask

  function automatic accT makeAcc(input logic [LINE_ADDR_W-1:0] e,
      input logic [LINE_ADDR_W-1:0] o, input logic [BANK_W-1:0] b,
      input logic [BLOW_W-1:0] bl, input logic [3:0] flags);
    accT a;
    a.addrE = e;
    a.addrO = o;
    a.banks = b;
    a.blow = bl;
    {a.oh, a.eh, a.ol, a.el} = flags;
    return a;
  endfunction

  // small address space so overlaps are common
  function automatic accT randAcc();
    logic [31:0] r;
    accT a;
    r = $random(seed);
    a.addrE = {34'b0, r[1:0]};
    a.addrO = a.addrE + LINE_ADDR_W'(1);
    a.banks = $random(seed) & $random(seed) & $random(seed);
    a.blow = r[5:2];
    {a.oh, a.eh, a.ol, a.el} = r[9:6];
    return a;
  endfunction

  task automatic allocLoad(input accT a, input int ii);
    newEn = 1'b1;
    newA = a;
    newIi = II_W'(ii);
    tick();
    newEn = 1'b0;
  endtask

  task automatic storeCheck(input accT a);
    chkEn = 1'b1;
    chkA = a;
    tick();
    chkEn = 1'b0;
  endtask

  // snoop bits land two edges after the strobe
  task automatic snoopLine(input logic [SNOOP_W-1:0] sn);
    snoopEn = 1'b1;
    snoopAddr = sn;
    tick();
    snoopEn = 1'b0;
    tick();
  endtask

  task automatic retire(input int ii, input logic hit, input logic confl, input logic smp);
    freeEn = 1'b1;
    freeIi = II_W'(ii);
    @(negedge clk);
    check("freeHit", freeHit, hit);
    check("freeConfl", freeConfl, confl);
    check("freeConflSmp", freeConflSmp, smp);
    tick();
    freeEn = 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    accT a;
    accT b;
    seed = 9480;
    errors = 0;
    checks = 0;
    tests = 0;
    testErrors = 0;
    nextIi = 100;
    rst = 1'b1;
    except = 1'b0;
    newEn = 1'b0;
    chkEn = 1'b0;
    snoopEn = 1'b0;
    freeEn = 1'b0;
    newA = '0;
    chkA = '0;
    newIi = '0;
    freeIi = '0;
    snoopAddr = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;

    a = makeAcc(36'h123, 36'h124, 32'h0000_0003, 4'b0011, 4'b0001);
    allocLoad(a, 5);
    retire(5, 1'b1, 1'b0, 1'b0);
    retire(77, 1'b0, 1'b0, 1'b0);
    finishTest("alloc and retire");

    a = makeAcc(36'h200, 36'h201, 32'h0000_0010, 4'b0001, 4'b0001);
    allocLoad(a, 10);
    storeCheck(a);
    retire(10, 1'b1, 1'b1, 1'b0);
    b = a;
    b.blow = 4'b0010;
    allocLoad(a, 11);
    storeCheck(b);
    retire(11, 1'b1, 1'b0, 1'b0);
    b = a;
    b.banks = 32'h0010_0000;
    allocLoad(a, 12);
    storeCheck(b);
    retire(12, 1'b1, 1'b0, 1'b0);
    b = a;
    b.addrE = 36'h202;
    allocLoad(a, 13);
    storeCheck(b);
    retire(13, 1'b1, 1'b0, 1'b0);
    finishTest("store check");

    // check lands in the allocation cycle
    newEn = 1'b1;
    newA = a;
    newIi = II_W'(20);
    chkEn = 1'b1;
    chkA = a;
    tick();
    newEn = 1'b0;
    chkEn = 1'b0;
    retire(20, 1'b1, 1'b1, 1'b0);
    finishTest("same-cycle check");

    a = makeAcc(36'h300, 36'h301, 32'h0004_0000, 4'b1000, 4'b1000);
    allocLoad(a, 30);
    snoopLine({36'h301, 1'b1});
    retire(30, 1'b1, 1'b1, 1'b1);
    allocLoad(a, 31);
    snoopLine({36'h301, 1'b0});
    retire(31, 1'b1, 1'b0, 1'b0);
    finishTest("snoop");

    a = makeAcc(36'h400, 36'h401, 32'h0000_0001, 4'b1111, 4'b0001);
    for (int k = 0; k < MODEL_ENTRIES; k++) allocLoad(a, 40 + k);
    // 46 and 47 were offered during stall
    retire(46, 1'b0, 1'b0, 1'b0);
    @(negedge clk);
    check("doStall", doStall, 1'b1);
    tick();
    except = 1'b1;
    tick();
    except = 1'b0;
    retire(40, 1'b0, 1'b0, 1'b0);
    @(negedge clk);
    check("doStall", doStall, 1'b0);
    tick();
    finishTest("stall and flush");

    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      r = $random(seed);
      newEn = r[0];
      chkEn = r[2:1] == 2'b00;
      snoopEn = r[4:3] == 2'b00;
      freeEn = r[6:5] != 2'b00;
      freeIi = II_W'(nextIi - 1 - int'(r[9:7]));
      except = r[15:10] == 6'd0;
      snoopAddr = {33'b0, r[19:17], r[20]};
      newA = randAcc();
      chkA = randAcc();
      newIi = II_W'(nextIi);
      // indices never repeat, even for dropped loads
      if (newEn) nextIi++;
      tick();
    end
    newEn = 1'b0;
    chkEn = 1'b0;
    snoopEn = 1'b0;
    freeEn = 1'b0;
    except = 1'b0;
    tick();
    finishTest("random mix");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- hw/conflictMatch.sv
`timescale 1ns/1ps

module conflictMatch import ldqPkg::*; (
  input  logic [LINE_ADDR_W-1:0] addrE,
  input  logic [LINE_ADDR_W-1:0] addrO,
  input  logic [BANK_W-1:0]      banks,
  input  logic [BLOW_W-1:0]      blow,
  input  logic                   isOH,
  input  logic                   isEH,
  input  logic                   isOL,
  input  logic                   isEL,
  lsAccessIf.dst                 probe,
  input  logic [SNOOP_W-1:0]     snoopAddr,
  output logic                   chkHit,
  output logic                   snoopHit
);

  logic bankL, bankH, matchE, matchO, blowHit;
  logic [LINE_ADDR_W-1:0] snLine;
  logic snOdd, anyL, anyH, snMatchE, snMatchO;

  // store probe
  assign bankL = |(banks[HALF_BANKS-1:0] & probe.banks[HALF_BANKS-1:0]);
  assign bankH = |(banks[BANK_W-1:HALF_BANKS] & probe.banks[BANK_W-1:HALF_BANKS]);
  assign matchE = probe.addrE == addrE;
  assign matchO = probe.addrO == addrO;
  assign blowHit = |(blow & probe.blow);

  assign chkHit = blowHit & (isOH & probe.isOH & matchO & bankH |
                             isOL & probe.isOL & matchO & bankL |
                             isEH & probe.isEH & matchE & bankH |
                             isEL & probe.isEL & matchE & bankL);

  // snoop covers a whole line, so any bank in a half and all bytes count
  assign snLine = snoopAddr[SNOOP_W-1:1];
  assign snOdd = snoopAddr[0];
  assign anyL = |banks[HALF_BANKS-1:0];
  assign anyH = |banks[BANK_W-1:HALF_BANKS];
  assign snMatchE = snLine == addrE;
  assign snMatchO = snLine == addrO;

  assign snoopHit = (|blow) & (snOdd & isOH & snMatchO & anyH |
                               snOdd & isOL & snMatchO & anyL |
                               ~snOdd & isEH & snMatchE & anyH |
                               ~snOdd & isEL & snMatchE & anyL);

endmodule

//--- hw/ldqArray.sv
`timescale 1ns/1ps

module ldqArray import ldqPkg::*; #(
  parameter int ENTRIES = 8
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               except,
  lsAccessIf.dst             newAcc,
  input  logic [II_W-1:0]    newIi,
  input  logic               newEn,
  lsAccessIf.dst             chkAcc,
  input  logic               chkEn,
  input  logic [SNOOP_W-1:0] snoopAddr,
  input  logic               snoopEn,
  input  logic [II_W-1:0]    freeIi,
  input  logic               freeEn,
  output logic               freeHit,
  output logic               freeConfl,
  output logic               freeConflSmp
);

  logic [ENTRIES-1:0] validVec;
  logic [ENTRIES-1:0] pickVec;
  logic [ENTRIES-1:0] allocVec;
  logic [ENTRIES-1:0] freeHitVec;
  logic [ENTRIES-1:0] freeConflVec;
  logic [ENTRIES-1:0] freeSmpVec;
  logic [SNOOP_W-1:0] snoopAddrQ;
  logic               snoopEnQ;
  logic               newChkHit;
  logic               newConfl;

  // lowest free slot wins
  always_comb begin
    pickVec = '0;
    for (int i = ENTRIES - 1; i >= 0; i--) begin
      if (!validVec[i]) begin
        pickVec = '0;
        pickVec[i] = 1'b1;
      end
    end
  end

  assign allocVec = pickVec & {ENTRIES{newEn}};

  always_ff @(posedge clk) begin
    if (rst) begin
      snoopEnQ <= 1'b0;
    end else begin
      snoopEnQ <= snoopEn;
    end
  end

  always_ff @(posedge clk) begin
    snoopAddrQ <= snoopAddr;
  end

  // a store checked in the allocation cycle still counts against the new load
  conflictMatch newMatch (
    .addrE    (newAcc.addrE),
    .addrO    (newAcc.addrO),
    .banks    (newAcc.banks),
    .blow     (newAcc.blow),
    .isOH     (newAcc.isOH),
    .isEH     (newAcc.isEH),
    .isOL     (newAcc.isOL),
    .isEL     (newAcc.isEL),
    .probe    (chkAcc),
    .snoopAddr(snoopAddrQ),
    .chkHit   (newChkHit),
    .snoopHit ()
  );

  assign newConfl = chkEn & newChkHit;

  for (genvar i = 0; i < ENTRIES; i++) begin : gEntry
    ldqEntry entry (
      .clk         (clk),
      .rst         (rst),
      .except      (except),
      .newAcc      (newAcc),
      .newIi       (newIi),
      .alloc       (allocVec[i]),
      .newConfl    (newConfl),
      .chkAcc      (chkAcc),
      .chkEn       (chkEn),
      .snoopAddr   (snoopAddrQ),
      .snoopEn     (snoopEnQ),
      .freeIi      (freeIi),
      .freeEn      (freeEn),
      .valid       (validVec[i]),
      .freeHit     (freeHitVec[i]),
      .freeConfl   (freeConflVec[i]),
      .freeConflSmp(freeSmpVec[i])
    );
  end

  // indices are unique among live loads, so at most one slot answers
  assign freeHit = |freeHitVec;
  assign freeConfl = |freeConflVec;
  assign freeConflSmp = |freeSmpVec;

  // at most one slot comes alive per edge
  oneAlloc: assert property (@(posedge clk) disable iff (rst)
    $onehot0(validVec & ~$past(validVec)))
    else $error("ldqArray: more than one slot allocated");

  // stall from the counter has to keep allocations off a full queue
  noFullAlloc: assert property (@(posedge clk) disable iff (rst) newEn |-> !(&validVec))
    else $error("ldqArray: newEn with no free slot");

endmodule

//--- hw/ldqEntry.sv
`timescale 1ns/1ps

module ldqEntry import ldqPkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               except,
  lsAccessIf.dst             newAcc,
  input  logic [II_W-1:0]    newIi,
  input  logic               alloc,
  input  logic               newConfl,
  lsAccessIf.dst             chkAcc,
  input  logic               chkEn,
  input  logic [SNOOP_W-1:0] snoopAddr,
  input  logic               snoopEn,
  input  logic [II_W-1:0]    freeIi,
  input  logic               freeEn,
  output logic               valid,
  output logic               freeHit,
  output logic               freeConfl,
  output logic               freeConflSmp
);

  logic [LINE_ADDR_W-1:0] addrE;
  logic [LINE_ADDR_W-1:0] addrO;
  logic [BANK_W-1:0]      banks;
  logic [BLOW_W-1:0]      blow;
  logic                   isOH, isEH, isOL, isEL;
  logic [II_W-1:0]        ii;
  logic                   confl;
  logic                   conflSmp;
  logic                   chkHit;
  logic                   snoopHit;

  conflictMatch match0 (
    .addrE    (addrE),
    .addrO    (addrO),
    .banks    (banks),
    .blow     (blow),
    .isOH     (isOH),
    .isEH     (isEH),
    .isOL     (isOL),
    .isEL     (isEL),
    .probe    (chkAcc),
    .snoopAddr(snoopAddr),
    .chkHit   (chkHit),
    .snoopHit (snoopHit)
  );

  // same-cycle retire lookup
  assign freeHit = valid & freeEn & (freeIi == ii);
  assign freeConfl = freeHit & confl;
  assign freeConflSmp = freeHit & conflSmp;

  always_ff @(posedge clk) begin
    if (alloc) begin
      addrE <= newAcc.addrE;
      addrO <= newAcc.addrO;
      banks <= newAcc.banks;
      blow <= newAcc.blow;
      isOH <= newAcc.isOH;
      isEH <= newAcc.isEH;
      isOL <= newAcc.isOL;
      isEL <= newAcc.isEL;
      ii <= newIi;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
      confl <= 1'b0;
      conflSmp <= 1'b0;
    end else if (except) begin
      valid <= 1'b0;
    end else if (alloc) begin
      valid <= 1'b1;
      confl <= newConfl;
      conflSmp <= 1'b0;
    end else if (valid) begin
      // sticky until the slot is reused
      confl <= confl | (chkEn & chkHit) | (snoopEn & snoopHit);
      conflSmp <= conflSmp | (snoopEn & snoopHit);
      if (freeHit) begin
        valid <= 1'b0;
      end
    end
  end

  // slot picker must only hand out free slots
  allocFree: assert property (@(posedge clk) disable iff (rst) alloc |-> !valid)
    else $error("ldqEntry: alloc into a live slot");

endmodule

//--- hw/ldqPkg.sv
package ldqPkg;

  // even or odd half of a line address
  localparam int LINE_ADDR_W = 36;

  // bank mask with the low half in the bottom bits
  localparam int BANK_W = 32;
  localparam int HALF_BANKS = BANK_W / 2;

  // byte-low mask inside a bank
  localparam int BLOW_W = 4;

  // instruction index carried by every load
  localparam int II_W = 10;

  // snoop word has the line address on top and the odd select in bit 0
  localparam int SNOOP_W = LINE_ADDR_W + 1;

endpackage

//--- hw/loadQueue.sv
`timescale 1ns/1ps

module loadQueue import ldqPkg::*; #(
  parameter int ENTRIES = 8,
  parameter int STALL_LIMIT = 6
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   except,
  input  logic                   newEn,
  input  logic [LINE_ADDR_W-1:0] newAddrE,
  input  logic [LINE_ADDR_W-1:0] newAddrO,
  input  logic [BANK_W-1:0]      newBanks,
  input  logic [BLOW_W-1:0]      newBlow,
  input  logic                   newIsOH,
  input  logic                   newIsEH,
  input  logic                   newIsOL,
  input  logic                   newIsEL,
  input  logic [II_W-1:0]        newIi,
  input  logic                   chkEn,
  input  logic [LINE_ADDR_W-1:0] chkAddrE,
  input  logic [LINE_ADDR_W-1:0] chkAddrO,
  input  logic [BANK_W-1:0]      chkBanks,
  input  logic [BLOW_W-1:0]      chkBlow,
  input  logic                   chkIsOH,
  input  logic                   chkIsEH,
  input  logic                   chkIsOL,
  input  logic                   chkIsEL,
  input  logic                   snoopEn,
  input  logic [SNOOP_W-1:0]     snoopAddr,
  input  logic                   freeEn,
  input  logic [II_W-1:0]        freeIi,
  output logic                   freeHit,
  output logic                   freeConfl,
  output logic                   freeConflSmp,
  output logic                   doStall
);

  lsAccessIf newAcc ();
  lsAccessIf chkAcc ();

  logic accept;

  assign newAcc.addrE = newAddrE;
  assign newAcc.addrO = newAddrO;
  assign newAcc.banks = newBanks;
  assign newAcc.blow = newBlow;
  assign newAcc.isOH = newIsOH;
  assign newAcc.isEH = newIsEH;
  assign newAcc.isOL = newIsOL;
  assign newAcc.isEL = newIsEL;

  assign chkAcc.addrE = chkAddrE;
  assign chkAcc.addrO = chkAddrO;
  assign chkAcc.banks = chkBanks;
  assign chkAcc.blow = chkBlow;
  assign chkAcc.isOH = chkIsOH;
  assign chkAcc.isEH = chkIsEH;
  assign chkAcc.isOL = chkIsOL;
  assign chkAcc.isEL = chkIsEL;

  // loads offered during stall are dropped
  assign accept = newEn & ~doStall;

  ldqArray #(.ENTRIES(ENTRIES)) array0 (
    .clk         (clk),
    .rst         (rst),
    .except      (except),
    .newAcc      (newAcc),
    .newIi       (newIi),
    .newEn       (accept),
    .chkAcc      (chkAcc),
    .chkEn       (chkEn),
    .snoopAddr   (snoopAddr),
    .snoopEn     (snoopEn),
    .freeIi      (freeIi),
    .freeEn      (freeEn),
    .freeHit     (freeHit),
    .freeConfl   (freeConfl),
    .freeConflSmp(freeConflSmp)
  );

  occupancyCounter #(.ENTRIES(ENTRIES), .STALL_LIMIT(STALL_LIMIT)) counter0 (
    .clk    (clk),
    .rst    (rst),
    .except (except),
    .inc    (accept),
    .dec    (freeHit),
    .doStall(doStall)
  );

endmodule

//--- hw/lsAccessIf.sv
`timescale 1ns/1ps

interface lsAccessIf import ldqPkg::*; ();

  logic [LINE_ADDR_W-1:0] addrE;
  logic [LINE_ADDR_W-1:0] addrO;
  logic [BANK_W-1:0]      banks;
  logic [BLOW_W-1:0]      blow;
  // which of the four line/bank halves the access touches
  logic                   isOH;
  logic                   isEH;
  logic                   isOL;
  logic                   isEL;

  modport src (
    output addrE, addrO, banks, blow,
    output isOH, isEH, isOL, isEL
  );

  modport dst (
    input addrE, addrO, banks, blow,
    input isOH, isEH, isOL, isEL
  );

endinterface

//--- hw/occupancyCounter.sv
`timescale 1ns/1ps

module occupancyCounter #(
  parameter int ENTRIES = 8,
  parameter int STALL_LIMIT = 6
) (
  input  logic clk,
  input  logic rst,
  input  logic except,
  input  logic inc,
  input  logic dec,
  output logic doStall
);

  localparam int CNT_W = $clog2(ENTRIES + 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (except) begin
      count <= '0;
    end else begin
      case ({inc, dec})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // from the registered count only
  assign doStall = count >= CNT_W'(STALL_LIMIT);

  noUnderflow: assert property (@(posedge clk) disable iff (rst) dec |-> count != '0)
    else $error("occupancyCounter: retire with no live load");

  noOverflow: assert property (@(posedge clk) disable iff (rst) count <= CNT_W'(ENTRIES))
    else $error("occupancyCounter: count beyond ENTRIES");

endmodule

//--- sim.f
+incdir+bench
hw/ldqPkg.sv
hw/lsAccessIf.sv
hw/conflictMatch.sv
hw/ldqEntry.sv
hw/ldqArray.sv
hw/occupancyCounter.sv
hw/loadQueue.sv
bench/tbLoadQueue.sv
